//--- verilog/params_pkg.sv
`default_nettype none

package params_pkg;

  localparam int ADDR_WIDTH     = 6;
  localparam int MEM_SIZE       = 64;
  localparam int DATA_WIDTH     = 16;
  localparam int REG_ADDR_WIDTH = 3;

  localparam logic [ADDR_WIDTH-1:0] RESET_PC = 6'd1; // word 0 only via jump.

  // unlisted codes decode as no-op.
  typedef enum logic [3:0] {
    OP_ALU  = 4'h1,
    OP_ADDI = 4'h2,
    OP_BEQ  = 4'h3,
    OP_JMP  = 4'h4
  } opcode_t;

  typedef enum logic [2:0] {
    FN_ADD = 3'd0,
    FN_SUB = 3'd1,
    FN_AND = 3'd2,
    FN_OR  = 3'd3,
    FN_XOR = 3'd4
  } alu_fn_t;

  typedef struct packed {
    opcode_t                   opcode;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [REG_ADDR_WIDTH-1:0] rs2;
    alu_fn_t                   funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_t                   opcode;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [ADDR_WIDTH-1:0]     imm; // also a branch or jump target.
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instruction_t;

endpackage : params_pkg

`default_nettype wire

//--- verilog/imem.sv
`timescale 1ns/1ps
`default_nettype none

module imem (
  input  logic                              clk_i,
  input  logic                              load_en_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0] load_addr_i,
  input  logic [params_pkg::DATA_WIDTH-1:0] load_data_i,
  input  logic                              req_valid_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0] req_pc_i,
  output logic                              instr_valid_o,
  output params_pkg::instruction_t          instr_o
);

  import params_pkg::*;

  logic [DATA_WIDTH-1:0] mem [MEM_SIZE];

  logic         valid_q1;
  logic         valid_q2;
  instruction_t data_q1;
  instruction_t data_q2;

  always_ff @(posedge clk_i) begin
    if (load_en_i) begin
      mem[load_addr_i] <= load_data_i;
    end
  end

  // two stages give the fixed read latency.
  always_ff @(posedge clk_i) begin
    valid_q1 <= req_valid_i;
    valid_q2 <= valid_q1;
    data_q1  <= mem[req_pc_i];
    data_q2  <= data_q1;
  end

  assign instr_valid_o = valid_q2;
  assign instr_o       = valid_q2 ? data_q2 : '0;

endmodule : imem

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              run_i,
  input  logic                              alu_branch_taken_i,
  input  logic                              is_jump_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0] pc_branch_offset_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0] jump_address_i,
  input  logic                              instr_valid_i,
  input  params_pkg::instruction_t          instr_i,
  output logic                              imem_req_valid_o,
  output logic [params_pkg::ADDR_WIDTH-1:0] imem_req_pc_o,
  output logic                              dec_valid_o,
  output logic [params_pkg::ADDR_WIDTH-1:0] dec_pc_o,
  output params_pkg::instruction_t          instruction_o
);

  import params_pkg::*;

  typedef enum logic [1:0] {
    IDLE     = 2'b00,
    MEM_REQ  = 2'b01,
    MEM_WAIT = 2'b10,
    FLUSH    = 2'b11
  } state_t;

  state_t state;
  state_t state_d;

  logic [ADDR_WIDTH-1:0] pc;
  logic [ADDR_WIDTH-1:0] pc_d;
  logic [ADDR_WIDTH-1:0] branch_target;

  always_comb begin
    imem_req_valid_o = 1'b0;
    imem_req_pc_o    = pc;
    dec_valid_o      = 1'b0;
    dec_pc_o         = pc;
    instruction_o    = '0;
    state_d          = state;
    pc_d             = pc;

    case (state)
      IDLE: begin
        if (run_i) begin
          state_d = MEM_REQ;
        end
      end
      MEM_REQ: begin
        imem_req_valid_o = 1'b1;
        state_d          = MEM_WAIT;
      end
      MEM_WAIT: begin
        if (alu_branch_taken_i || is_jump_i) begin
          state_d = FLUSH; // fetch in flight is now stale.
        end else if (instr_valid_i) begin
          dec_valid_o   = 1'b1;
          instruction_o = instr_i;
          pc_d          = pc + ADDR_WIDTH'(1); // wraps modulo MEM_SIZE.
          state_d       = MEM_REQ;
        end
      end
      FLUSH: begin
        // drop the returning word, then restart at the target.
        if (instr_valid_i) begin
          pc_d    = branch_target;
          state_d = MEM_REQ;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state <= IDLE;
      pc    <= RESET_PC;
    end else begin
      state <= state_d;
      pc    <= pc_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_branch_taken_i) begin
      branch_target <= pc_branch_offset_i;
    end else if (is_jump_i) begin
      branch_target <= jump_address_i;
    end
  end

endmodule : fetch_stage

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic [params_pkg::REG_ADDR_WIDTH-1:0] ra_addr_i,
  input  logic [params_pkg::REG_ADDR_WIDTH-1:0] rb_addr_i,
  input  logic                                  we_i,
  input  logic [params_pkg::REG_ADDR_WIDTH-1:0] wa_addr_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]     wd_data_i,
  output logic [params_pkg::DATA_WIDTH-1:0]     ra_data_o,
  output logic [params_pkg::DATA_WIDTH-1:0]     rb_data_o
);

  import params_pkg::*;

  logic [DATA_WIDTH-1:0] regs [2**REG_ADDR_WIDTH];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[wa_addr_i] <= wd_data_i;
    end
  end

  // no bypass, a write shows up next cycle.
  assign ra_data_o = regs[ra_addr_i];
  assign rb_data_o = regs[rb_addr_i];

endmodule : regfile

`default_nettype wire

//--- verilog/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  dec_valid_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0]     dec_pc_i,
  input  params_pkg::instruction_t              instruction_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]     ra_data_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]     rb_data_i,
  output logic [params_pkg::REG_ADDR_WIDTH-1:0] ra_addr_o,
  output logic [params_pkg::REG_ADDR_WIDTH-1:0] rb_addr_o,
  output logic                                  we_o,
  output logic [params_pkg::REG_ADDR_WIDTH-1:0] wa_addr_o,
  output logic [params_pkg::DATA_WIDTH-1:0]     wd_data_o,
  output logic                                  branch_taken_o,
  output logic [params_pkg::ADDR_WIDTH-1:0]     branch_target_o,
  output logic                                  is_jump_o,
  output logic [params_pkg::ADDR_WIDTH-1:0]     jump_address_o,
  output logic                                  retire_valid_o,
  output logic [params_pkg::ADDR_WIDTH-1:0]     retire_pc_o
);

  import params_pkg::*;

  logic                  valid_q;
  logic [ADDR_WIDTH-1:0] pc_q;
  instruction_t          instr_q;
  opcode_t               opcode;
  logic [DATA_WIDTH-1:0] imm_ext;
  logic [DATA_WIDTH-1:0] alu_result;
  logic                  operands_equal;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      instr_q <= instruction_i;
      pc_q    <= dec_pc_i;
    end
  end

  assign opcode = instr_q.r.opcode; // same position in both formats.

  // beq compares rd with rs1, so port b reads rd there.
  assign ra_addr_o = instr_q.r.rs1;
  assign rb_addr_o = (opcode == OP_BEQ) ? instr_q.i.rd : instr_q.r.rs2;

  assign imm_ext = {{(DATA_WIDTH-ADDR_WIDTH){instr_q.i.imm[ADDR_WIDTH-1]}}, instr_q.i.imm};

  always_comb begin
    case (instr_q.r.funct)
      FN_ADD:  alu_result = ra_data_i + rb_data_i;
      FN_SUB:  alu_result = ra_data_i - rb_data_i;
      FN_AND:  alu_result = ra_data_i & rb_data_i;
      FN_OR:   alu_result = ra_data_i | rb_data_i;
      FN_XOR:  alu_result = ra_data_i ^ rb_data_i;
      default: alu_result = '0;
    endcase
  end

  assign operands_equal = (ra_data_i == rb_data_i);

  assign we_o      = valid_q && ((opcode == OP_ALU) || (opcode == OP_ADDI));
  assign wa_addr_o = instr_q.r.rd;
  assign wd_data_o = (opcode == OP_ADDI) ? ra_data_i + imm_ext : alu_result;

  assign retire_valid_o = valid_q;
  assign retire_pc_o    = pc_q;

  // redirect goes out one cycle after retirement.
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      branch_taken_o <= 1'b0;
      is_jump_o      <= 1'b0;
    end else begin
      branch_taken_o <= valid_q && (opcode == OP_BEQ) && operands_equal;
      is_jump_o      <= valid_q && (opcode == OP_JMP);
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_q && (opcode == OP_BEQ) && operands_equal) begin
      branch_target_o <= instr_q.i.imm;
    end
    if (valid_q && (opcode == OP_JMP)) begin
      jump_address_o <= instr_q.i.imm;
    end
  end

endmodule : exec_stage

`default_nettype wire

//--- verilog/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  run_i,
  input  logic                                  load_en_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0]     load_addr_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]     load_data_i,
  output logic                                  retire_valid_o,
  output logic [params_pkg::ADDR_WIDTH-1:0]     retire_pc_o,
  output logic                                  wb_en_o,
  output logic [params_pkg::REG_ADDR_WIDTH-1:0] wb_addr_o,
  output logic [params_pkg::DATA_WIDTH-1:0]     wb_data_o
);

  import params_pkg::*;

  logic                      imem_req_valid;
  logic [ADDR_WIDTH-1:0]     imem_req_pc;
  logic                      instr_valid;
  instruction_t              instr;
  logic                      dec_valid;
  logic [ADDR_WIDTH-1:0]     dec_pc;
  instruction_t              instruction;
  logic [REG_ADDR_WIDTH-1:0] ra_addr;
  logic [REG_ADDR_WIDTH-1:0] rb_addr;
  logic [DATA_WIDTH-1:0]     ra_data;
  logic [DATA_WIDTH-1:0]     rb_data;
  logic                      branch_taken;
  logic [ADDR_WIDTH-1:0]     branch_target_addr;
  logic                      is_jump;
  logic [ADDR_WIDTH-1:0]     jump_address;

  fetch_stage fetch_stage_i (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .run_i              (run_i),
    .alu_branch_taken_i (branch_taken),
    .is_jump_i          (is_jump),
    .pc_branch_offset_i (branch_target_addr),
    .jump_address_i     (jump_address),
    .instr_valid_i      (instr_valid),
    .instr_i            (instr),
    .imem_req_valid_o   (imem_req_valid),
    .imem_req_pc_o      (imem_req_pc),
    .dec_valid_o        (dec_valid),
    .dec_pc_o           (dec_pc),
    .instruction_o      (instruction)
  );

  imem imem_i (
    .clk_i         (clk_i),
    .load_en_i     (load_en_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .req_valid_i   (imem_req_valid),
    .req_pc_i      (imem_req_pc),
    .instr_valid_o (instr_valid),
    .instr_o       (instr)
  );

  regfile regfile_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .ra_addr_i (ra_addr),
    .rb_addr_i (rb_addr),
    .we_i      (wb_en_o),
    .wa_addr_i (wb_addr_o),
    .wd_data_i (wb_data_o),
    .ra_data_o (ra_data),
    .rb_data_o (rb_data)
  );

  exec_stage exec_stage_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .dec_valid_i     (dec_valid),
    .dec_pc_i        (dec_pc),
    .instruction_i   (instruction),
    .ra_data_i       (ra_data),
    .rb_data_i       (rb_data),
    .ra_addr_o       (ra_addr),
    .rb_addr_o       (rb_addr),
    .we_o            (wb_en_o),
    .wa_addr_o       (wb_addr_o),
    .wd_data_o       (wb_data_o),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target_addr),
    .is_jump_o       (is_jump),
    .jump_address_o  (jump_address),
    .retire_valid_o  (retire_valid_o),
    .retire_pc_o     (retire_pc_o)
  );

endmodule : cpu_core

`default_nettype wire

//--- bench/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  run_i,
  input  logic                                  retire_valid_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0]     retire_pc_i,
  input  logic                                  wb_en_i,
  input  logic [params_pkg::REG_ADDR_WIDTH-1:0] wb_addr_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]     wb_data_i,
  input  logic [params_pkg::ADDR_WIDTH-1:0]     exp_pc_i,
  input  logic                                  exp_wb_en_i,
  input  logic [params_pkg::REG_ADDR_WIDTH-1:0] exp_wb_addr_i,
  input  logic [params_pkg::DATA_WIDTH-1:0]     exp_wb_data_i,
  input  logic [3:0]                            exp_gap_i,
  output int                                    error_count_o
);

  import params_pkg::*;

  int   errors = 0;
  int   since_last;
  logic have_last;

  assign error_count_o = errors;

  task automatic report_value(input string name, input logic [15:0] got,
                              input logic [15:0] want);
    $display("Fail at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, want);
    errors++;
  endtask

  task automatic report_event(input string what);
    $display("Error at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic check_retirement();
    if (!run_i) begin
      report_event("an instruction retired while run_i was low");
    end
    if (retire_pc_i !== exp_pc_i) begin
      report_value("retire_pc_o", 16'(retire_pc_i), 16'(exp_pc_i));
    end
    if (wb_en_i !== exp_wb_en_i) begin
      report_value("wb_en_o", 16'(wb_en_i), 16'(exp_wb_en_i));
    end else if (exp_wb_en_i) begin
      if (wb_addr_i !== exp_wb_addr_i) begin
        report_value("wb_addr_o", 16'(wb_addr_i), 16'(exp_wb_addr_i));
      end
      if (wb_data_i !== exp_wb_data_i) begin
        report_value("wb_data_o", wb_data_i, exp_wb_data_i);
      end
    end
    // first retirement after reset has no spacing to check.
    if (have_last && since_last != int'(exp_gap_i)) begin
      $display("Fail at %0t ns: retire_valid_o spacing is %0d cycles, expected %0d",
               $time, since_last, exp_gap_i);
      errors++;
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_i) begin
      have_last  <= 1'b0;
      since_last <= 0;
    end else begin
      since_last <= since_last + 1;
      if (retire_valid_i) begin
        check_retirement();
        have_last  <= 1'b1;
        since_last <= 1;
      end else if (wb_en_i) begin
        report_event("wb_en_o is high but no instruction retired");
      end
    end
  end

endmodule : core_checker

`default_nettype wire

//--- bench/tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;

  import params_pkg::*;

  localparam int RESET_CYCLES  = 8;
  localparam int IDLE_CYCLES   = 20;
  localparam int ALU_COUNT     = 24;
  localparam int ADDI_COUNT    = 20;
  localparam int BRANCH_COUNT  = 30;
  localparam int RANDOM_COUNT  = 300;
  localparam int TOTAL_RETIRE  = ALU_COUNT + ADDI_COUNT + BRANCH_COUNT + RANDOM_COUNT;
  localparam int CYCLE_LIMIT   = 6 * TOTAL_RETIRE + 4 * (MEM_SIZE + 1)
                                 + 5 * (RESET_CYCLES + 1) + IDLE_CYCLES + 50;

  logic                      clk_i;
  logic                      rst_i;
  logic                      run_i;
  logic                      load_en_i;
  logic [ADDR_WIDTH-1:0]     load_addr_i;
  logic [DATA_WIDTH-1:0]     load_data_i;
  logic                      retire_valid_o;
  logic [ADDR_WIDTH-1:0]     retire_pc_o;
  logic                      wb_en_o;
  logic [REG_ADDR_WIDTH-1:0] wb_addr_o;
  logic [DATA_WIDTH-1:0]     wb_data_o;

  logic [DATA_WIDTH-1:0]     prog [MEM_SIZE]; // also the model's memory.
  logic [DATA_WIDTH-1:0]     m_regs [8];
  logic [ADDR_WIDTH-1:0]     m_pc;
  logic [31:0]               lfsr;
  int                        retired;
  int                        total_retired;
  int                        cycles;
  int                        error_count;
  logic                      timed_out;

  logic [ADDR_WIDTH-1:0]     exp_pc;
  logic                      exp_wb_en;
  logic [REG_ADDR_WIDTH-1:0] exp_wb_addr;
  logic [DATA_WIDTH-1:0]     exp_wb_data;
  logic [3:0]                exp_gap;

  cpu_core cpu_core_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .run_i          (run_i),
    .load_en_i      (load_en_i),
    .load_addr_i    (load_addr_i),
    .load_data_i    (load_data_i),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .wb_en_o        (wb_en_o),
    .wb_addr_o      (wb_addr_o),
    .wb_data_o      (wb_data_o)
  );

  core_checker core_checker_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .run_i          (run_i),
    .retire_valid_i (retire_valid_o),
    .retire_pc_i    (retire_pc_o),
    .wb_en_i        (wb_en_o),
    .wb_addr_i      (wb_addr_o),
    .wb_data_i      (wb_data_o),
    .exp_pc_i       (exp_pc),
    .exp_wb_en_i    (exp_wb_en),
    .exp_wb_addr_i  (exp_wb_addr),
    .exp_wb_data_i  (exp_wb_data),
    .exp_gap_i      (exp_gap),
    .error_count_o  (error_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit.
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[14:0], fb};
    end
    return v;
  endfunction

  function automatic logic [15:0] r_word(input logic [2:0] rd, input logic [2:0] rs1,
                                         input logic [2:0] rs2, input logic [2:0] fn);
    return {OP_ALU, rd, rs1, rs2, fn};
  endfunction

  function automatic logic [15:0] i_word(input opcode_t op, input logic [2:0] rd,
                                         input logic [2:0] rs1, input logic [5:0] imm);
    return {op, rd, rs1, imm};
  endfunction

  // one instruction of the model at pc, without committing it.
  function automatic void iss_step(
    input  logic [ADDR_WIDTH-1:0]     pc,
    output logic [ADDR_WIDTH-1:0]     next_pc,
    output logic                      redirect,
    output logic                      wb_en,
    output logic [REG_ADDR_WIDTH-1:0] wb_addr,
    output logic [DATA_WIDTH-1:0]     wb_data
  );
    logic [DATA_WIDTH-1:0] word;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH-1:0] d;
    word     = prog[pc];
    a        = m_regs[word[8:6]];  // rs1.
    b        = m_regs[word[5:3]];  // rs2.
    d        = m_regs[word[11:9]]; // rd.
    next_pc  = pc + ADDR_WIDTH'(1);
    redirect = 1'b0;
    wb_en    = 1'b0;
    wb_addr  = word[11:9];
    wb_data  = '0;
    case (word[15:12])
      OP_ALU: begin
        wb_en = 1'b1;
        case (word[2:0])
          FN_ADD:  wb_data = a + b;
          FN_SUB:  wb_data = a - b;
          FN_AND:  wb_data = a & b;
          FN_OR:   wb_data = a | b;
          FN_XOR:  wb_data = a ^ b;
          default: wb_data = '0;
        endcase
      end
      OP_ADDI: begin
        wb_en   = 1'b1;
        wb_data = a + {{(DATA_WIDTH-ADDR_WIDTH){word[ADDR_WIDTH-1]}}, word[ADDR_WIDTH-1:0]};
      end
      OP_BEQ: begin
        if (d == a) begin
          next_pc  = word[ADDR_WIDTH-1:0];
          redirect = 1'b1;
        end
      end
      OP_JMP: begin
        next_pc  = word[ADDR_WIDTH-1:0];
        redirect = 1'b1;
      end
      default: begin
      end
    endcase
  endfunction

  task automatic predict();
    logic [ADDR_WIDTH-1:0]     npc;
    logic                      redir;
    logic                      wen;
    logic [REG_ADDR_WIDTH-1:0] wa;
    logic [DATA_WIDTH-1:0]     wd;
    iss_step(m_pc, npc, redir, wen, wa, wd);
    exp_pc      <= m_pc;
    exp_wb_en   <= wen;
    exp_wb_addr <= wa;
    exp_wb_data <= wd;
  endtask

  // commit the model on every retirement, then predict the next one.
  always @(posedge clk_i) begin : model_commit
    logic [ADDR_WIDTH-1:0]     npc;
    logic                      redir;
    logic                      wen;
    logic [REG_ADDR_WIDTH-1:0] wa;
    logic [DATA_WIDTH-1:0]     wd;
    if (rst_i && retire_valid_o) begin
      iss_step(m_pc, npc, redir, wen, wa, wd);
      if (wen) begin
        m_regs[wa] = wd;
      end
      m_pc = npc;
      retired++;
      total_retired++;
      exp_gap <= redir ? 4'd6 : 4'd3; // flush costs three cycles.
      predict();
    end
  end

  task automatic clear_program();
    for (int a = 0; a < MEM_SIZE; a++) begin
      prog[a] = '0; // opcode 0 is a no-op.
    end
  endtask

  task automatic build_alu_program();
    clear_program();
    for (int k = 0; k < 4; k++) begin
      prog[RESET_PC + k] = i_word(OP_ADDI, 3'(k + 1), 3'd0, 6'(rand_bits(6)));
    end
    for (int k = 4; k < ALU_COUNT; k++) begin
      prog[RESET_PC + k] = r_word(3'(rand_bits(3)), 3'(rand_bits(3)),
                                  3'(rand_bits(3)), 3'(k % 8));
    end
  endtask

  task automatic build_addi_program();
    logic [5:0] imm;
    clear_program();
    for (int k = 0; k < ADDI_COUNT; k++) begin
      case (k)
        0:       imm = 6'h20; // most negative.
        1:       imm = 6'h3f;
        2:       imm = 6'h1f; // most positive.
        default: imm = 6'(rand_bits(6));
      endcase
      prog[RESET_PC + k] = i_word(OP_ADDI, 3'(rand_bits(3)), 3'(rand_bits(3)), imm);
    end
  endtask

  task automatic build_branch_program();
    clear_program();
    prog[0]  = i_word(OP_ADDI, 3'd4, 3'd0, 6'h3f);
    prog[1]  = i_word(OP_ADDI, 3'd1, 3'd0, 6'd5);
    prog[2]  = i_word(OP_ADDI, 3'd2, 3'd0, 6'd5);
    prog[3]  = i_word(OP_BEQ, 3'd1, 3'd2, 6'd6);  // taken.
    prog[4]  = i_word(OP_ADDI, 3'd7, 3'd0, 6'd1); // flushed path.
    prog[5]  = i_word(OP_ADDI, 3'd7, 3'd0, 6'd2);
    prog[6]  = i_word(OP_BEQ, 3'd1, 3'd0, 6'd4);  // not taken.
    prog[7]  = i_word(OP_JMP, 3'd0, 3'd0, 6'd10);
    prog[8]  = i_word(OP_ADDI, 3'd7, 3'd0, 6'd3);
    prog[9]  = i_word(OP_ADDI, 3'd7, 3'd0, 6'd4);
    prog[10] = i_word(OP_ADDI, 3'd3, 3'd3, 6'd1);
    prog[11] = i_word(OP_BEQ, 3'd3, 3'd1, 6'd13); // loop exit at r3 == 5.
    prog[12] = i_word(OP_JMP, 3'd0, 3'd0, 6'd10);
    prog[13] = i_word(OP_JMP, 3'd0, 3'd0, 6'd0);
  endtask

  task automatic build_random_program();
    logic [2:0] sel;
    logic [5:0] imm;
    int         tgt;
    for (int a = 0; a < MEM_SIZE; a++) begin
      sel = 3'(rand_bits(3));
      imm = 6'(rand_bits(6));
      tgt = a + 1 + int'(imm[3:0]); // forward only, so the pc keeps moving.
      if (tgt >= MEM_SIZE) begin
        tgt = 0;
      end
      case (sel)
        3'd0, 3'd1, 3'd2: prog[a] = r_word(3'(rand_bits(3)), 3'(rand_bits(3)),
                                           3'(rand_bits(3)), 3'(rand_bits(3)));
        3'd3, 3'd4: prog[a] = i_word(OP_ADDI, 3'(rand_bits(3)), 3'(rand_bits(3)), imm);
        3'd5: prog[a] = i_word(OP_BEQ, 3'(rand_bits(3)), 3'(rand_bits(3)), 6'(tgt));
        3'd6: prog[a] = i_word(OP_JMP, 3'd0, 3'd0, 6'(tgt));
        default: prog[a] = {1'b1, 15'(rand_bits(15))}; // unlisted opcode.
      endcase
    end
    prog[MEM_SIZE-1] = r_word(3'd5, 3'd6, 3'd7, 3'(rand_bits(3))); // wraps to word 0.
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_i     = 1'b0;
    run_i     = 1'b0;
    load_en_i = 1'b0;
    for (int r = 0; r < 8; r++) begin
      m_regs[r] = '0;
    end
    m_pc    = RESET_PC;
    retired = 0;
    exp_gap <= 4'd3;
    predict();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_i = 1'b1;
  endtask

  task automatic load_program();
    for (int a = 0; a < MEM_SIZE; a++) begin
      @(negedge clk_i);
      load_en_i   = 1'b1;
      load_addr_i = ADDR_WIDTH'(a);
      load_data_i = prog[a];
    end
    @(negedge clk_i);
    load_en_i = 1'b0;
  endtask

  task automatic run_program(input int count);
    load_program();
    run_i = 1'b1;
    while (retired < count) begin
      @(negedge clk_i);
    end
    run_i = 1'b0;
    rst_i = 1'b0; // stop the core before the next program.
  endtask

  task automatic finish_run();
    $display("Closing: %0d instructions retired, %0d errors, %0d timeouts",
             total_retired, error_count, timed_out);
    if (error_count == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  initial begin
    rst_i         = 1'b0;
    run_i         = 1'b0;
    load_en_i     = 1'b0;
    load_addr_i   = '0;
    load_data_i   = '0;
    lfsr          = 32'h5b5f_18ba;
    total_retired = 0;
    timed_out     = 1'b0;
    clear_program();
    apply_reset();
    repeat (IDLE_CYCLES) @(negedge clk_i); // idle core must not retire.
    build_alu_program();
    apply_reset();
    run_program(ALU_COUNT);
    build_addi_program();
    apply_reset();
    run_program(ADDI_COUNT);
    build_branch_program();
    apply_reset();
    run_program(BRANCH_COUNT);
    build_random_program();
    apply_reset();
    run_program(RANDOM_COUNT);
    finish_run();
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles: the DUT stopped retiring instructions", cycles);
    timed_out = 1'b1;
    finish_run();
  end

endmodule : tb_cpu_core

`default_nettype wire

//--- project.f
verilog/params_pkg.sv
verilog/imem.sv
verilog/fetch_stage.sv
verilog/regfile.sv
verilog/exec_stage.sv
verilog/cpu_core.sv
bench/core_checker.sv
bench/tb_cpu_core.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - verilog/params_pkg.sv
  - verilog/imem.sv
  - verilog/fetch_stage.sv
  - verilog/regfile.sv
  - verilog/exec_stage.sv
  - verilog/cpu_core.sv
  - target: test
    files:
      - bench/core_checker.sv
      - bench/tb_cpu_core.sv
